// ==== Bender.yml ====
package:
  name: mips_processor

sources:
  - include_dirs:
      - logic
    files:
      - logic/mipsPkg.sv
      - logic/aluUnit.sv
      - logic/wordMemory.sv
      - logic/registerFile.sv
      - logic/controlSequencer.sv
      - logic/mipsProcessor.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/mipsProcessor_assertions.sv
      - tb/mipsProcessorTb.sv

// ==== logic/aluUnit.sv ====
`timescale 1ns/10ps

module aluUnit (
	input  mipsPkg::aluOpT aluOp,
	input  mipsPkg::wordT  operandA,
	input  mipsPkg::wordT  operandB,
	output mipsPkg::wordT  aluResult,
	output logic           aluZero
);

	mipsPkg::wordT sum;
	mipsPkg::wordT difference;
	logic          lessSigned;
	logic          lessUnsigned;

	assign sum          = operandA + operandB;
	assign difference   = operandA - operandB;
	assign lessSigned   = $signed(operandA) < $signed(operandB);
	assign lessUnsigned = operandA < operandB;

	always_comb begin
		case (aluOp)
			mipsPkg::aluAdd: begin
				aluResult = sum;  // Wraps, no overflow trap
			end
			mipsPkg::aluSub: begin
				aluResult = difference;
			end
			mipsPkg::aluAnd: begin
				aluResult = operandA & operandB;
			end
			mipsPkg::aluOr: begin
				aluResult = operandA | operandB;
			end
			mipsPkg::aluXor: begin
				aluResult = operandA ^ operandB;
			end
			mipsPkg::aluNor: begin
				aluResult = ~(operandA | operandB);
			end
			mipsPkg::aluSlt: begin
				aluResult = {31'b0, lessSigned};
			end
			mipsPkg::aluSltu: begin
				aluResult = {31'b0, lessUnsigned};
			end
			mipsPkg::aluLui: begin
				aluResult = {operandB[15:0], 16'b0};  // Low half cleared
			end
			default: begin
				aluResult = '0;
			end
		endcase
	end

	// beq runs a subtract, so this flags equal operands
	assign aluZero = (aluResult == '0);

endmodule

// ==== logic/controlSequencer.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"

module controlSequencer (
	input  logic              CLK,
	input  logic              reset,
	input  mipsPkg::wordT     readData,
	input  mipsPkg::wordT     aluResult,
	input  logic              aluZero,
	output mipsPkg::memIndexT memIndex,
	output logic              memWrite,
	output mipsPkg::aluOpT    aluOp,
	output mipsPkg::wordT     operandB,
	input  mipsPkg::wordT     rtData,
	output mipsPkg::regAddrT  readAddrA,
	output mipsPkg::regAddrT  readAddrB,
	output mipsPkg::regAddrT  writeAddr,
	output logic              regWrite,
	output logic              memToReg,
	output logic              storeValid
);

	mipsPkg::seqStateT state;
	mipsPkg::byteAddrT pc;
	mipsPkg::wordT     ir;
	logic [5:0]        opcode;
	logic [5:0]        funct;
	mipsPkg::wordT     signImm;
	mipsPkg::wordT     zeroImm;
	mipsPkg::byteAddrT pcPlus4;
	mipsPkg::byteAddrT branchTarget;
	logic              knownOp;    // Low for opcodes and functs outside the subset
	logic              dataAccess;

	assign opcode       = ir[31:26];
	assign funct        = ir[5:0];
	assign readAddrA    = ir[25:21];  // rs
	assign readAddrB    = ir[20:16];  // rt
	assign writeAddr    = (opcode == `MIPS_OP_RTYPE) ? ir[15:11] : ir[20:16];
	assign signImm      = {{16{ir[15]}}, ir[15:0]};
	assign zeroImm      = {16'b0, ir[15:0]};
	assign pcPlus4      = pc + 32'd4;
	assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};

	// Opcode and funct to ALU operation and second operand
	always_comb begin
		aluOp    = mipsPkg::aluAdd;
		operandB = signImm;  // addi, lw, sw
		knownOp  = 1'b1;
		case (opcode)
			`MIPS_OP_RTYPE: begin
				operandB = rtData;
				case (funct)
					`MIPS_FN_ADD:  aluOp = mipsPkg::aluAdd;
					`MIPS_FN_SUB:  aluOp = mipsPkg::aluSub;
					`MIPS_FN_AND:  aluOp = mipsPkg::aluAnd;
					`MIPS_FN_OR:   aluOp = mipsPkg::aluOr;
					`MIPS_FN_XOR:  aluOp = mipsPkg::aluXor;
					`MIPS_FN_NOR:  aluOp = mipsPkg::aluNor;
					`MIPS_FN_SLT:  aluOp = mipsPkg::aluSlt;
					`MIPS_FN_SLTU: aluOp = mipsPkg::aluSltu;
					default:       knownOp = 1'b0;
				endcase
			end
			`MIPS_OP_ADDI, `MIPS_OP_LW, `MIPS_OP_SW: aluOp = mipsPkg::aluAdd;
			`MIPS_OP_ANDI: begin
				aluOp    = mipsPkg::aluAnd;
				operandB = zeroImm;
			end
			`MIPS_OP_ORI: begin
				aluOp    = mipsPkg::aluOr;
				operandB = zeroImm;
			end
			`MIPS_OP_LUI: begin
				aluOp    = mipsPkg::aluLui;
				operandB = zeroImm;
			end
			`MIPS_OP_BEQ: begin
				aluOp    = mipsPkg::aluSub;  // Zero result means equal
				operandB = rtData;
			end
			default: knownOp = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= mipsPkg::seqFetch;
			pc    <= '0;
			ir    <= '0;
		end else begin
			case (state)
				mipsPkg::seqFetch: state <= mipsPkg::seqDecode;
				mipsPkg::seqDecode: begin
					ir    <= readData;  // Word fetched last cycle
					state <= mipsPkg::seqExecute;
				end
				mipsPkg::seqExecute: begin
					pc <= (opcode == `MIPS_OP_BEQ && aluZero) ? branchTarget : pcPlus4;
					if (!knownOp || opcode == `MIPS_OP_BEQ)
						state <= mipsPkg::seqFetch;
					else if (opcode == `MIPS_OP_SW)
						state <= mipsPkg::seqMemWrite;
					else if (opcode == `MIPS_OP_LW)
						state <= mipsPkg::seqMemRead;
					else
						state <= mipsPkg::seqWriteBack;
				end
				mipsPkg::seqMemRead: state <= mipsPkg::seqLoadWriteBack;
				default: state <= mipsPkg::seqFetch;
			endcase
		end
	end

	assign dataAccess = (state == mipsPkg::seqMemWrite) || (state == mipsPkg::seqMemRead);
	assign memIndex   = dataAccess ? aluResult[`MIPS_MEM_ADDR_BITS+1:2]
	                               : pc[`MIPS_MEM_ADDR_BITS+1:2];
	assign memWrite   = (state == mipsPkg::seqMemWrite);
	assign storeValid = (state == mipsPkg::seqMemWrite);
	assign regWrite   = (state == mipsPkg::seqWriteBack) || (state == mipsPkg::seqLoadWriteBack);
	assign memToReg   = (state == mipsPkg::seqLoadWriteBack);

endmodule

// ==== logic/mipsPkg.sv ====
`include "mips_settings.svh"

package mipsPkg;

	typedef logic [`MIPS_WORD_BITS-1:0]     wordT;     // Data or instruction word
	typedef logic [`MIPS_REG_ADDR_BITS-1:0] regAddrT;
	typedef logic [`MIPS_MEM_ADDR_BITS-1:0] memIndexT; // Word index into memory
	typedef logic [`MIPS_WORD_BITS-1:0]     byteAddrT; // PC and store addresses

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt,   // Signed compare
		aluSltu,  // Unsigned compare
		aluLui
	} aluOpT;

	// One pass per instruction always starts and ends in seqFetch
	typedef enum logic [2:0] {
		seqFetch,
		seqDecode,
		seqExecute,
		seqWriteBack,
		seqMemWrite,
		seqMemRead,
		seqLoadWriteBack
	} seqStateT;

endpackage

// ==== logic/mipsProcessor.sv ====
`timescale 1ns/10ps

module mipsProcessor (
	input  logic              CLK,
	input  logic              reset,
	input  logic              loadEnable,
	input  mipsPkg::memIndexT loadIndex,
	input  mipsPkg::wordT     loadData,
	output logic              storeValid,
	output mipsPkg::byteAddrT storeAddress,
	output mipsPkg::wordT     storeData
);

	mipsPkg::wordT     readData;
	mipsPkg::wordT     aluResult;
	logic              aluZero;
	mipsPkg::memIndexT memIndex;
	logic              memWrite;
	mipsPkg::aluOpT    aluOp;
	mipsPkg::wordT     rsData;
	mipsPkg::wordT     rtData;
	mipsPkg::wordT     operandB;
	mipsPkg::regAddrT  readAddrA;
	mipsPkg::regAddrT  readAddrB;
	mipsPkg::regAddrT  writeAddr;
	logic              regWrite;
	logic              memToReg;

	controlSequencer sequencer (
		.CLK        (CLK),
		.reset      (reset),
		.readData   (readData),
		.aluResult  (aluResult),
		.aluZero    (aluZero),
		.memIndex   (memIndex),
		.memWrite   (memWrite),
		.aluOp      (aluOp),
		.operandB   (operandB),
		.rtData     (rtData),
		.readAddrA  (readAddrA),
		.readAddrB  (readAddrB),
		.writeAddr  (writeAddr),
		.regWrite   (regWrite),
		.memToReg   (memToReg),
		.storeValid (storeValid)
	);

	aluUnit alu (
		.aluOp     (aluOp),
		.operandA  (rsData),
		.operandB  (operandB),
		.aluResult (aluResult),
		.aluZero   (aluZero)
	);

	wordMemory memory (
		.CLK        (CLK),
		.memIndex   (memIndex),
		.memWrite   (memWrite),
		.writeData  (rtData),      // sw stores rt
		.loadEnable (loadEnable),
		.loadIndex  (loadIndex),
		.loadData   (loadData),
		.readData   (readData)
	);

	registerFile regFile (
		.CLK       (CLK),
		.readAddrA (readAddrA),
		.readAddrB (readAddrB),
		.rsData    (rsData),
		.rtData    (rtData),
		.writeAddr (writeAddr),
		.regWrite  (regWrite),
		.memToReg  (memToReg),
		.aluResult (aluResult),
		.readData  (readData)
	);

	assign storeAddress = aluResult;  // Effective address in memWrite
	assign storeData    = rtData;

endmodule

// ==== logic/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`define MIPS_WORD_BITS      32
`define MIPS_MEM_WORDS      256
`define MIPS_MEM_ADDR_BITS  8   // Word index, byte address bits 9:2
`define MIPS_REG_ADDR_BITS  5

// Primary opcodes, instruction bits 31:26
`define MIPS_OP_RTYPE  6'b000000
`define MIPS_OP_ADDI   6'b001000
`define MIPS_OP_ANDI   6'b001100
`define MIPS_OP_ORI    6'b001101
`define MIPS_OP_LUI    6'b001111
`define MIPS_OP_LW     6'b100011
`define MIPS_OP_SW     6'b101011
`define MIPS_OP_BEQ    6'b000100

// R-type funct field, instruction bits 5:0
`define MIPS_FN_ADD   6'b100000
`define MIPS_FN_SUB   6'b100010
`define MIPS_FN_AND   6'b100100
`define MIPS_FN_OR    6'b100101
`define MIPS_FN_XOR   6'b100110
`define MIPS_FN_NOR   6'b100111
`define MIPS_FN_SLT   6'b101010
`define MIPS_FN_SLTU  6'b101011

`endif

// ==== logic/registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
	input  logic             CLK,
	input  mipsPkg::regAddrT readAddrA,
	input  mipsPkg::regAddrT readAddrB,
	output mipsPkg::wordT    rsData,
	output mipsPkg::wordT    rtData,
	input  mipsPkg::regAddrT writeAddr,
	input  logic             regWrite,
	input  logic             memToReg,
	input  mipsPkg::wordT    aluResult,
	input  mipsPkg::wordT    readData
);

	mipsPkg::wordT regs [0:31];
	mipsPkg::wordT writeValue;

	assign writeValue = memToReg ? readData : aluResult;  // Loaded word or ALU result

	always_ff @(posedge CLK) begin
		if (regWrite && writeAddr != '0)
			regs[writeAddr] <= writeValue;
	end

	// Register 0 is never written, so force its reads
	assign rsData = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign rtData = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== logic/wordMemory.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"

module wordMemory (
	input  logic              CLK,
	input  mipsPkg::memIndexT memIndex,
	input  logic              memWrite,
	input  mipsPkg::wordT     writeData,
	input  logic              loadEnable,
	input  mipsPkg::memIndexT loadIndex,
	input  mipsPkg::wordT     loadData,
	output mipsPkg::wordT     readData
);

	// Program and data share this array
	mipsPkg::wordT memArray [0:`MIPS_MEM_WORDS-1];

	always_ff @(posedge CLK) begin
		if (loadEnable)
			memArray[loadIndex] <= loadData;  // Loader beats the core
		else if (memWrite)
			memArray[memIndex] <= writeData;
	end

	// Registered read, data one cycle after the index
	always_ff @(posedge CLK) begin
		readData <= memArray[memIndex];
	end

endmodule

// ==== mipsProcessor.f ====
+incdir+logic
logic/mipsPkg.sv
logic/aluUnit.sv
logic/wordMemory.sv
logic/registerFile.sv
logic/controlSequencer.sv
logic/mipsProcessor.sv
tb/mipsProcessor_assertions.sv
tb/mipsProcessorTb.sv

// ==== tb/mipsProcessorTb.sv ====
`timescale 1ns/10ps
`include "mips_settings.svh"

module mipsProcessorTb;

	localparam int resetCycles = 4;
	localparam int quietCycles = 12;  // Idle window that catches extra stores

	logic              CLK;
	logic              reset;
	logic              loadEnable;
	mipsPkg::memIndexT loadIndex;
	mipsPkg::wordT     loadData;
	logic              storeValid;
	mipsPkg::byteAddrT storeAddress;
	mipsPkg::wordT     storeData;

	// One entry per test with indexes into the flat queues below
	string         testName [$];
	int            testBound [$];
	int            progStart [$];
	int            progLength [$];
	int            storeStart [$];
	int            storeCount [$];
	int            progIndex [$];
	mipsPkg::wordT progWord [$];
	mipsPkg::wordT expAddress [$];
	mipsPkg::wordT expData [$];

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;

	mipsProcessor dut (
		.CLK          (CLK),
		.reset        (reset),
		.loadEnable   (loadEnable),
		.loadIndex    (loadIndex),
		.loadData     (loadData),
		.storeValid   (storeValid),
		.storeAddress (storeAddress),
		.storeData    (storeData)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic compareValue(input string name, input string what,
			input mipsPkg::wordT expected, input mipsPkg::wordT actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("Mismatch in test %0s, %0s expected %h actual %h",
				name, what, expected, actual);
		end
	endtask

	task automatic readCases();
		int            fd;
		int            got;
		int            badReads;
		int            first;
		int            count;
		int            i;
		string         tok;
		string         line;
		mipsPkg::wordT value;
		mipsPkg::wordT valueB;
		badReads = 0;
		fd = $fopen("tb/mips_cases.txt", "r");
		if (fd == 0) begin
			errorCount++;
			$display("Cannot open tb/mips_cases.txt, no tests were run");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					got = $fgets(line, fd);  // Rest of a comment line
				end else if (tok == "test") begin
					got = $fscanf(fd, "%s %d", tok, count);
					if (got != 2)
						badReads++;
					testName.push_back(tok);
					testBound.push_back(count);
					progStart.push_back(progWord.size());
					progLength.push_back(0);
					storeStart.push_back(expData.size());
					storeCount.push_back(0);
				end else if (tok == "prog") begin
					got = $fscanf(fd, "%d %d", first, count);
					if (got != 2)
						badReads++;
					if (first + count > `MIPS_MEM_WORDS) begin
						errorCount++;
						$display("Program of test %0s runs past the end of memory",
							testName[testName.size()-1]);
					end
					progLength[progLength.size()-1] = count;
					for (i = 0; i < count; i++) begin
						got = $fscanf(fd, "%h", value);
						if (got != 1)
							badReads++;
						progIndex.push_back(first + i);
						progWord.push_back(value);
					end
				end else if (tok == "stores") begin
					got = $fscanf(fd, "%d", count);
					if (got != 1)
						badReads++;
					storeCount[storeCount.size()-1] = count;
					for (i = 0; i < count; i++) begin
						got = $fscanf(fd, "%h %h", value, valueB);
						if (got != 2)
							badReads++;
						expAddress.push_back(value);
						expData.push_back(valueB);
					end
				end else begin
					errorCount++;
					$display("Unknown entry %0s in the case file", tok);
				end
			end
			if (badReads > 0) begin
				errorCount++;
				$display("The case file has %0d fields that could not be read", badReads);
			end
			$fclose(fd);
		end
	endtask

	// Worst case of 5 cycles per instruction plus load, reset and idle time
	function automatic int computeLimit();
		int total;
		int t;
		total = 50;
		for (t = 0; t < testName.size(); t++)
			total += 5 * testBound[t] + progLength[t] + 2 + resetCycles + quietCycles;
		return total;
	endfunction

	task automatic runTest(input int t);
		int seen;
		int waited;
		int errorsBefore;
		int i;
		errorsBefore = errorCount;
		@(posedge CLK);
		reset <= 1'b1;
		for (i = 0; i < progLength[t]; i++) begin
			@(posedge CLK);
			loadEnable <= 1'b1;
			loadIndex  <= progIndex[progStart[t] + i];
			loadData   <= progWord[progStart[t] + i];
		end
		@(posedge CLK);
		loadEnable <= 1'b0;
		repeat (resetCycles) @(posedge CLK);
		reset <= 1'b0;
		seen   = 0;
		waited = 0;
		while (seen < storeCount[t] && waited < 5 * testBound[t]) begin
			@(negedge CLK);  // Store port settled mid-cycle
			waited++;
			if (storeValid) begin
				compareValue(testName[t], "store address",
					expAddress[storeStart[t] + seen], storeAddress);
				compareValue(testName[t], "store data", expData[storeStart[t] + seen], storeData);
				seen++;
			end
		end
		if (seen < storeCount[t]) begin
			errorCount++;
			$display("Test %0s is missing stores, only %0d of %0d were seen",
				testName[t], seen, storeCount[t]);
		end
		repeat (quietCycles) begin
			@(negedge CLK);
			if (storeValid) begin
				errorCount++;
				$display("Test %0s made an extra store of %h at address %h",
					testName[t], storeData, storeAddress);
			end
		end
		$display("Test %0s finished, %0d of %0d stores seen, %0d errors",
			testName[t], seen, storeCount[t], errorCount - errorsBefore);
	endtask

	initial begin
		int t;
		reset      = 1'b1;
		loadEnable = 1'b0;
		loadIndex  = '0;
		loadData   = '0;
		readCases();
		cycleLimit = computeLimit() + resetCycles;
		repeat (resetCycles) @(posedge CLK);
		for (t = 0; t < testName.size(); t++)
			runTest(t);
		errorCount += dut.storeChecks.failCount;  // Failed store assertions
		$display("Totals: %0d tests, %0d checks, %0d errors",
			testName.size(), checkCount, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Hang guard for the whole run
	initial begin
		wait (cycleLimit > 0);
		while (cycleCount < cycleLimit) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout, the run did not finish within %0d cycles", cycleLimit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tb/mipsProcessor_assertions.sv ====
`timescale 1ns/10ps

module mipsProcessor_assertions (
	input logic CLK,
	input logic reset,
	input logic storeValid
);

	logic armed = 1'b0;  // Low only in the first cycle
	int   failCount = 0; // Failed assertions so far

	always_ff @(posedge CLK) begin
		armed <= 1'b1;
	end

	// Sequencer sits in fetch for the whole reset
	property quietDuringReset;
		@(posedge CLK) armed && reset && $past(reset) |-> !storeValid;
	endproperty

	property quietAfterReset;
		@(posedge CLK) $fell(reset) |-> !storeValid;
	endproperty

	// memWrite always goes back to fetch
	property singleCycleStore;
		@(posedge CLK) storeValid |=> !storeValid;
	endproperty

	assert property (quietDuringReset) else begin
		failCount++;
		$error("storeValid high while reset is held");
	end
	assert property (quietAfterReset) else begin
		failCount++;
		$error("storeValid high in the first cycle after reset");
	end
	assert property (singleCycleStore) else begin
		failCount++;
		$error("storeValid high in two consecutive cycles");
	end

endmodule

bind mipsProcessor mipsProcessor_assertions storeChecks (
	.CLK        (CLK),
	.reset      (reset),
	.storeValid (storeValid)
);

// ==== tb/mips_cases.txt ====
# test <name> <instruction bound>
# prog <first word index> <word count> <instruction words in hex>
# stores <count> then <byte address> <data> pairs in hex in store order
test rtypeArith 16
prog 0 15 2001000C 2002FFFB 00221820 AC030200 00221822 AC030204 00221824 AC030208
	00221825 AC03020C 00221826 AC030210 00221827 AC030214 1000FFFF
stores 6 00000200 00000007 00000204 00000011 00000208 00000008
	0000020C FFFFFFFF 00000210 FFFFFFF7 00000214 00000000
test immediates 10
prog 0 9 2001FFFD AC010220 3022F0F0 AC020224 34038001 AC030228 3C03ABCD AC03022C
	1000FFFF
stores 4 00000220 FFFFFFFD 00000224 0000F0F0 00000228 00008001 0000022C ABCD0000
test compares 8
prog 0 7 2001FFFF 20020001 0022182A 0022202B AC030240 AC040244 1000FFFF
stores 2 00000240 00000001 00000244 00000000
test memRoundTrip 7
prog 0 6 3C011234 34215678 AC010260 8C020260 AC020264 1000FFFF
stores 2 00000260 12345678 00000264 12345678
test branchLoop 16
prog 0 9 20010003 AC010280 2021FFFF 10200001 1000FFFC 20020007 10220001 AC020284 1000FFFF
stores 4 00000280 00000003 00000280 00000002 00000280 00000001 00000284 00000007
test registerZero 4
prog 0 3 20000055 AC0002A0 1000FFFF
stores 1 000002A0 00000000
